// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Width of a data word and of an instruction.
`define CPU_BITS 16

// Word address width of the memory and port buses.
`define CPU_ADDRESS_BITS 16

// Width of a register select field.
`define CPU_REGISTER_BITS 4

// First fetch address after reset.
`define CPU_RESET_PC 16'h0000

`endif

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

	// Instruction opcodes, top nibble of every word.
	typedef enum logic [3:0] {
		OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_LDI, OP_ADDI, OP_LD, OP_ST, OP_IN, OP_OUT,
		OP_JZ, OP_JMP, OP_HALT
	} opcode_t;

	typedef struct packed {
		opcode_t op;
		logic [`CPU_REGISTER_BITS-1:0] rd;
		logic [`CPU_REGISTER_BITS-1:0] ra;
		logic [`CPU_REGISTER_BITS-1:0] rb;
	} reg_form_t;

	typedef struct packed {
		opcode_t op;
		logic [`CPU_REGISTER_BITS-1:0] rd;
		logic [`CPU_BITS-`CPU_REGISTER_BITS-5:0] imm;
	} imm_form_t;

	// One instruction word, read as registers or as an immediate.
	typedef union packed {
		reg_form_t reg_form;
		imm_form_t imm_form;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_PASS_B, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR
	} alu_op_t;

	// Decoded control for one instruction.
	typedef struct packed {
		alu_op_t alu_op;
		logic use_imm;
		logic sign_ext;
		logic wr_reg;
		logic wr_flags;
		logic load;
		logic store;
		logic port_rd;
		logic port_wr;
		logic branch_z;
		logic jump;
		logic halt;
		logic [`CPU_REGISTER_BITS-1:0] rd;
		logic [`CPU_REGISTER_BITS-1:0] sel_a;
		logic [`CPU_REGISTER_BITS-1:0] sel_b;
		logic [`CPU_BITS-`CPU_REGISTER_BITS-5:0] imm;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/cpu_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

// One requester's view of the shared memory bus.
interface cpu_mem_if;
	logic [`CPU_ADDRESS_BITS-1:0] addr;
	logic [`CPU_BITS-1:0] wdata;
	logic wr;
	logic valid;
	logic ready;
	logic [`CPU_BITS-1:0] rdata;

	modport requester (output addr, output wdata, output wr, output valid,
		input ready, input rdata);
	modport arbiter (input addr, input wdata, input wr, input valid,
		output ready, output rdata);
endinterface

// Hand-over of fetched words to execute, and redirects back to fetch.
interface cpu_issue_if;
	cpu_pkg::instr_t instr;
	logic [`CPU_ADDRESS_BITS-1:0] pc;
	logic valid;
	logic take;
	logic load_pc;
	logic [`CPU_ADDRESS_BITS-1:0] new_pc;

	modport fetch (output instr, output pc, output valid,
		input take, input load_pc, input new_pc);
	modport execute (input instr, input pc, input valid,
		output take, output load_pc, output new_pc);
endinterface

`default_nettype wire

// ==== verilog/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
	input wire cpu_pkg::instr_t instr,
	output cpu_pkg::ctrl_t ctrl
);

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = cpu_pkg::ALU_PASS_B;
		ctrl.rd = instr.reg_form.rd;
		ctrl.sel_a = instr.reg_form.ra;
		ctrl.sel_b = instr.reg_form.rb;
		ctrl.imm = instr.imm_form.imm;
		case (instr.reg_form.op)
			cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
			cpu_pkg::OP_OR, cpu_pkg::OP_XOR: begin
				ctrl.alu_op = cpu_pkg::alu_op_t'(instr.reg_form.op[2:0]);
				ctrl.wr_reg = 1'b1;
				ctrl.wr_flags = 1'b1;
			end
			// Immediate forms read rd as operand A.
			cpu_pkg::OP_LDI: begin
				ctrl.use_imm = 1'b1;
				ctrl.wr_reg = 1'b1;
			end
			cpu_pkg::OP_ADDI: begin
				ctrl.alu_op = cpu_pkg::ALU_ADD;
				ctrl.sel_a = instr.imm_form.rd;
				ctrl.use_imm = 1'b1;
				ctrl.sign_ext = 1'b1;
				ctrl.wr_reg = 1'b1;
				ctrl.wr_flags = 1'b1;
			end
			cpu_pkg::OP_LD: begin
				ctrl.load = 1'b1;
				ctrl.wr_reg = 1'b1;
			end
			// Store and output send rd on the B port.
			cpu_pkg::OP_ST: begin
				ctrl.store = 1'b1;
				ctrl.sel_b = instr.reg_form.rd;
			end
			cpu_pkg::OP_IN: begin
				ctrl.port_rd = 1'b1;
				ctrl.wr_reg = 1'b1;
			end
			cpu_pkg::OP_OUT: begin
				ctrl.port_wr = 1'b1;
				ctrl.sel_b = instr.reg_form.rd;
			end
			cpu_pkg::OP_JZ: begin
				ctrl.branch_z = 1'b1;
				ctrl.sign_ext = 1'b1;
			end
			cpu_pkg::OP_JMP: ctrl.jump = 1'b1;
			cpu_pkg::OP_HALT: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_register_file (
	input wire CLK,
	input wire rst_n,
	input wire [`CPU_REGISTER_BITS-1:0] rd_sel_a,
	input wire [`CPU_REGISTER_BITS-1:0] rd_sel_b,
	output logic [`CPU_BITS-1:0] data_a,
	output logic [`CPU_BITS-1:0] data_b,
	input wire [`CPU_REGISTER_BITS-1:0] wr_sel,
	input wire [`CPU_BITS-1:0] wr_data,
	input wire wr_en
);

	localparam int NUM_REGS = 1 << `CPU_REGISTER_BITS;

	logic [`CPU_BITS-1:0] regs [NUM_REGS];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// Reads see the old value during a write cycle.
	assign data_a = regs[rd_sel_a];
	assign data_b = regs[rd_sel_b];

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module alu (
	input wire CLK,
	input wire rst_n,
	input wire [`CPU_BITS-1:0] a,
	input wire [`CPU_BITS-1:0] b,
	input wire cpu_pkg::alu_op_t op,
	output logic [`CPU_BITS-1:0] result,
	input wire flags_en,
	output logic z,
	output logic c,
	output logic s
);

	// One extra bit holds carry out or borrow.
	logic [`CPU_BITS:0] wide;

	always_comb begin
		case (op)
			cpu_pkg::ALU_ADD: wide = {1'b0, a} + {1'b0, b};
			cpu_pkg::ALU_SUB: wide = {1'b0, a} - {1'b0, b};
			cpu_pkg::ALU_AND: wide = {1'b0, a & b};
			cpu_pkg::ALU_OR: wide = {1'b0, a | b};
			cpu_pkg::ALU_XOR: wide = {1'b0, a ^ b};
			default: wide = {1'b0, b};
		endcase
	end

	assign result = wide[`CPU_BITS-1:0];

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			z <= 1'b0;
			c <= 1'b0;
			s <= 1'b0;
		end else if (flags_en) begin
			z <= (result == '0);
			c <= wide[`CPU_BITS];
			s <= result[`CPU_BITS-1];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_execute (
	input wire CLK,
	input wire rst_n,
	cpu_issue_if.execute issue,
	cpu_mem_if.requester data,
	output logic [`CPU_ADDRESS_BITS-1:0] port_address,
	output logic [`CPU_BITS-1:0] port_out,
	input wire [`CPU_BITS-1:0] port_in,
	output logic port_rd,
	output logic port_wr,
	output logic halted
);

	typedef enum logic [1:0] {S_IDLE, S_MEM_WAIT, S_HALTED} state_t;

	state_t state;
	cpu_pkg::ctrl_t ctrl;
	logic take;
	logic wait_done;
	logic z;
	logic [`CPU_BITS-1:0] data_a;
	logic [`CPU_BITS-1:0] data_b;
	logic [`CPU_BITS-1:0] imm_ext;
	logic [`CPU_BITS-1:0] alu_result;
	logic wr_en;
	logic [`CPU_REGISTER_BITS-1:0] wr_sel;
	logic [`CPU_BITS-1:0] wr_data;
	// Write-back owed by a load or port read.
	logic pend_wr;
	logic pend_port;
	logic [`CPU_REGISTER_BITS-1:0] pend_rd;

	cpu_decode dec0 (.instr(issue.instr), .ctrl(ctrl));

	cpu_register_file reg0 (
		.CLK(CLK), .rst_n(rst_n),
		.rd_sel_a(ctrl.sel_a), .rd_sel_b(ctrl.sel_b),
		.data_a(data_a), .data_b(data_b),
		.wr_sel(wr_sel), .wr_data(wr_data), .wr_en(wr_en)
	);

	alu alu0 (
		.CLK(CLK), .rst_n(rst_n),
		.a(data_a), .b(ctrl.use_imm ? imm_ext : data_b), .op(ctrl.alu_op),
		.result(alu_result), .flags_en(take && ctrl.wr_flags),
		.z(z), .c(), .s()
	);

	assign take = (state == S_IDLE) && issue.valid;
	assign wait_done = (state == S_MEM_WAIT) && (pend_port || data.ready);
	assign imm_ext = ctrl.sign_ext ? {{8{ctrl.imm[7]}}, ctrl.imm} : {8'h00, ctrl.imm};
	assign halted = (state == S_HALTED);

	// Branch targets are relative to the word after the branch.
	assign issue.take = take;
	assign issue.load_pc = take && (ctrl.jump || (ctrl.branch_z && z));
	assign issue.new_pc = ctrl.jump ? data_a : issue.pc + 16'd1 + imm_ext;

	always_comb begin
		if (state == S_MEM_WAIT) begin
			wr_en = wait_done && pend_wr;
			wr_sel = pend_rd;
			wr_data = pend_port ? port_in : data.rdata;
		end else begin
			wr_en = take && ctrl.wr_reg && !ctrl.load && !ctrl.port_rd;
			wr_sel = ctrl.rd;
			wr_data = alu_result;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			data.valid <= 1'b0;
			data.wr <= 1'b0;
			port_rd <= 1'b0;
			port_wr <= 1'b0;
			pend_wr <= 1'b0;
			pend_port <= 1'b0;
		end else begin
			port_rd <= take && ctrl.port_rd;
			port_wr <= take && ctrl.port_wr;
			case (state)
				S_IDLE: if (take) begin
					if (ctrl.halt) begin
						state <= S_HALTED;
					end else if (ctrl.load || ctrl.store || ctrl.port_rd) begin
						state <= S_MEM_WAIT;
						pend_wr <= ctrl.wr_reg;
						pend_port <= ctrl.port_rd;
					end
					data.valid <= ctrl.load || ctrl.store;
					data.wr <= ctrl.store;
				end
				S_MEM_WAIT: if (wait_done) begin
					state <= S_IDLE;
					data.valid <= 1'b0;
				end
				default: ;
			endcase
		end
	end

	// Bus addresses and write data come from the A and B read ports.
	always_ff @(posedge CLK) begin
		if (take) begin
			data.addr <= data_a;
			data.wdata <= data_b;
			port_address <= data_a;
			port_out <= data_b;
			pend_rd <= ctrl.rd;
		end
	end

	a_port_strobes: assert property (@(posedge CLK) disable iff (!rst_n)
		!(port_rd && port_wr));

endmodule

`default_nettype wire

// ==== verilog/cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_fetch (
	input wire CLK,
	input wire rst_n,
	cpu_mem_if.requester mem,
	cpu_issue_if.fetch issue
);

	logic [`CPU_ADDRESS_BITS-1:0] pc;
	logic [`CPU_ADDRESS_BITS-1:0] next_addr;
	logic [`CPU_ADDRESS_BITS-1:0] buf_pc;
	cpu_pkg::instr_t buf_instr;
	logic buf_valid;
	logic stale;
	logic resp;
	logic keep;
	logic buf_free;

	assign resp = mem.valid && mem.ready;
	// A word fetched before a redirect is thrown away.
	assign keep = resp && !stale && !issue.load_pc;
	assign buf_free = !buf_valid || issue.take || issue.load_pc;
	assign next_addr = issue.load_pc ? issue.new_pc : pc;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `CPU_RESET_PC;
			mem.valid <= 1'b0;
			stale <= 1'b0;
			buf_valid <= 1'b0;
		end else begin
			if (resp) begin
				mem.valid <= 1'b0;
				stale <= 1'b0;
			end else if (mem.valid && issue.load_pc) begin
				stale <= 1'b1;
			end
			if (!mem.valid && buf_free) begin
				mem.valid <= 1'b1;
				pc <= next_addr + 16'd1;
			end else if (issue.load_pc) begin
				pc <= issue.new_pc;
			end
			if (keep) begin
				buf_valid <= 1'b1;
			end else if (issue.take || issue.load_pc) begin
				buf_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!mem.valid && buf_free) begin
			mem.addr <= next_addr;
		end
		if (keep) begin
			buf_instr <= cpu_pkg::instr_t'(mem.rdata);
			buf_pc <= mem.addr;
		end
	end

	assign mem.wr = 1'b0;
	assign mem.wdata = '0;
	assign issue.valid = buf_valid;
	assign issue.instr = buf_instr;
	assign issue.pc = buf_pc;

	a_fetch_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		mem.valid && !mem.ready |=> mem.valid && $stable(mem.addr));

endmodule

`default_nettype wire

// ==== verilog/cpu_memory_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_memory_interface (
	input wire CLK,
	input wire rst_n,
	cpu_mem_if.arbiter fetch,
	cpu_mem_if.arbiter data,
	output logic [`CPU_ADDRESS_BITS-1:0] memory_address,
	output logic [`CPU_BITS-1:0] memory_out,
	output logic memory_wr,
	output logic memory_valid,
	input wire [`CPU_BITS-1:0] memory_in,
	input wire memory_ready
);

	logic busy;
	logic grant_data;
	logic sel_data;

	// Data traffic wins when the bus is free.
	assign sel_data = busy ? grant_data : data.valid;

	assign memory_valid = sel_data ? data.valid : fetch.valid;
	assign memory_address = sel_data ? data.addr : fetch.addr;
	assign memory_out = sel_data ? data.wdata : fetch.wdata;
	assign memory_wr = sel_data ? data.wr : fetch.wr;

	assign data.ready = memory_valid && memory_ready && sel_data;
	assign fetch.ready = memory_valid && memory_ready && !sel_data;
	assign data.rdata = sel_data ? memory_in : '0;
	assign fetch.rdata = sel_data ? '0 : memory_in;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			grant_data <= 1'b0;
		end else if (memory_valid && !memory_ready) begin
			busy <= 1'b1;
			grant_data <= sel_data;
		end else if (memory_ready) begin
			busy <= 1'b0;
		end
	end

	// The granted request stays on the bus until it is accepted.
	a_grant_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		memory_valid && !memory_ready |=> memory_valid && $stable(memory_address)
			&& $stable(memory_wr) && $stable(memory_out));

endmodule

`default_nettype wire

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
	input wire CLK,
	input wire rst_n,

	output logic [`CPU_ADDRESS_BITS-1:0] memory_address,
	input wire [`CPU_BITS-1:0] memory_in,
	output logic [`CPU_BITS-1:0] memory_out,
	output logic memory_valid,
	output logic memory_wr,
	input wire memory_ready,

	output logic [`CPU_ADDRESS_BITS-1:0] port_address,
	input wire [`CPU_BITS-1:0] port_in,
	output logic [`CPU_BITS-1:0] port_out,
	output logic port_rd,
	output logic port_wr,

	output logic halted
);

	cpu_mem_if fetch_bus ();
	cpu_mem_if data_bus ();
	cpu_issue_if issue_bus ();

	cpu_fetch fetch0 (.CLK(CLK), .rst_n(rst_n), .mem(fetch_bus), .issue(issue_bus));

	cpu_execute exec0 (
		.CLK(CLK), .rst_n(rst_n),
		.issue(issue_bus), .data(data_bus),
		.port_address(port_address), .port_out(port_out), .port_in(port_in),
		.port_rd(port_rd), .port_wr(port_wr),
		.halted(halted)
	);

	/* Single memory port shared by fetch and load/store. */
	cpu_memory_interface mem0 (
		.CLK(CLK), .rst_n(rst_n),
		.fetch(fetch_bus), .data(data_bus),
		.memory_address(memory_address), .memory_out(memory_out),
		.memory_wr(memory_wr), .memory_valid(memory_valid),
		.memory_in(memory_in), .memory_ready(memory_ready)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running testbench clock with an 8 ns period.
module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_tb;

	localparam int HALT_TIMEOUT = 3000;
	localparam int FETCH_TIMEOUT = 50;

	logic clk;
	logic rst_n;
	logic [`CPU_ADDRESS_BITS-1:0] memory_address;
	logic [`CPU_BITS-1:0] memory_in;
	logic [`CPU_BITS-1:0] memory_out;
	logic memory_valid;
	logic memory_wr;
	logic memory_ready;
	logic [`CPU_ADDRESS_BITS-1:0] port_address;
	logic [`CPU_BITS-1:0] port_in;
	logic [`CPU_BITS-1:0] port_out;
	logic port_rd;
	logic port_wr;
	logic halted;

	logic [`CPU_BITS-1:0] mem [256];
	logic [31:0] lcg_state = 32'h4ad1_758f;
	logic [1:0] waits;
	logic counting;
	logic [`CPU_ADDRESS_BITS-1:0] log_addr [$];
	logic [`CPU_BITS-1:0] log_data [$];
	logic [`CPU_ADDRESS_BITS-1:0] exp_addr [$];
	logic [`CPU_BITS-1:0] exp_data [$];
	logic [`CPU_BITS-1:0] prog [$];
	int test_errors;
	int total_errors;
	int tests_run;
	int tests_failing;

	tb_clock clock0 (.clk(clk));

	cpu_top dut (
		.CLK(clk), .rst_n(rst_n),
		.memory_address(memory_address), .memory_in(memory_in),
		.memory_out(memory_out), .memory_valid(memory_valid),
		.memory_wr(memory_wr), .memory_ready(memory_ready),
		.port_address(port_address), .port_in(port_in), .port_out(port_out),
		.port_rd(port_rd), .port_wr(port_wr),
		.halted(halted)
	);

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Unused memory holds HALT with the low byte of its own address.
	function automatic logic [`CPU_BITS-1:0] fill_word(input logic [7:0] addr);
		return {8'he0, addr};
	endfunction

	// Value that the port model returns for a port address.
	function automatic logic [`CPU_BITS-1:0] port_value(input logic [15:0] addr);
		return (addr * 16'h0101) ^ 16'h5a3c;
	endfunction

	function automatic logic [15:0] sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic [`CPU_BITS-1:0] enc_reg(input cpu_pkg::opcode_t op,
			input logic [3:0] rd, input logic [3:0] ra, input logic [3:0] rb);
		cpu_pkg::instr_t w;
		w.reg_form.op = op;
		w.reg_form.rd = rd;
		w.reg_form.ra = ra;
		w.reg_form.rb = rb;
		return w;
	endfunction

	function automatic logic [`CPU_BITS-1:0] enc_imm(input cpu_pkg::opcode_t op,
			input logic [3:0] rd, input logic [7:0] imm);
		cpu_pkg::instr_t w;
		w.imm_form.op = op;
		w.imm_form.rd = rd;
		w.imm_form.imm = imm;
		return w;
	endfunction

	// Memory model with 0 to 3 wait states per access.
	always @(negedge clk) begin
		if (!rst_n) begin
			memory_ready <= 1'b0;
			counting = 1'b0;
		end else if (memory_ready) begin
			memory_ready <= 1'b0;
			counting = 1'b0;
		end else if (memory_valid) begin
			if (!counting) begin
				waits = lcg_next() >> 30;
				counting = 1'b1;
			end
			if (waits == 2'd0) begin
				memory_ready <= 1'b1;
				memory_in <= mem[memory_address[7:0]];
				if (memory_wr) begin
					mem[memory_address[7:0]] <= memory_out;
				end
			end else begin
				waits = waits - 2'd1;
			end
		end
	end

	// Port model that answers read strobes and logs every write strobe.
	always @(negedge clk) begin
		if (port_rd) begin
			port_in <= port_value(port_address);
		end else begin
			port_in <= '0;
		end
		if (rst_n && port_wr) begin
			log_addr.push_back(port_address);
			log_data.push_back(port_out);
		end
	end

	task automatic compare_word(input string name, input logic [`CPU_BITS-1:0] got,
			input logic [`CPU_BITS-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_addr(input string name, input logic [`CPU_ADDRESS_BITS-1:0] got,
			input logic [`CPU_ADDRESS_BITS-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic expect_out(input logic [15:0] addr, input logic [15:0] data);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
	endtask

	task automatic check_port_log();
		if (log_addr.size() != exp_addr.size()) begin
			$display("port write count is %0d where %0d were expected",
				log_addr.size(), exp_addr.size());
			test_errors++;
		end
		for (int i = 0; i < log_addr.size() && i < exp_addr.size(); i++) begin
			compare_addr($sformatf("port_address[%0d]", i), log_addr[i], exp_addr[i]);
			compare_word($sformatf("port_out[%0d]", i), log_data[i], exp_data[i]);
		end
	endtask

	task automatic start_test();
		test_errors = 0;
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("%s: ok", name);
		end else begin
			tests_failing++;
			$display("%s: %0d errors", name, test_errors);
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i[7:0]);
		end
		foreach (prog[i]) begin
			mem[i] = prog[i];
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n = 1'b0;
		log_addr.delete();
		log_data.delete();
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic wait_halted();
		int cycles;
		cycles = 0;
		while (!halted && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			$display("timeout, the CPU did not halt within %0d cycles", HALT_TIMEOUT);
			test_errors++;
		end
		// Extra cycles show any write that follows HALT.
		repeat (20) @(negedge clk);
	endtask

	task automatic run_program();
		load_program();
		apply_reset();
		wait_halted();
		check_port_log();
	endtask

	task automatic test_reset_state();
		int cycles;
		start_test();
		prog.push_back(enc_reg(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0));
		load_program();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		compare_bit("memory_valid", memory_valid, 1'b0);
		compare_bit("memory_wr", memory_wr, 1'b0);
		compare_bit("port_rd", port_rd, 1'b0);
		compare_bit("port_wr", port_wr, 1'b0);
		compare_bit("halted", halted, 1'b0);
		repeat (12) @(negedge clk);
		rst_n = 1'b1;
		cycles = 0;
		while (!memory_valid && cycles < FETCH_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!memory_valid) begin
			$display("timeout, no fetch was issued after reset");
			test_errors++;
		end else begin
			compare_addr("memory_address", memory_address, `CPU_RESET_PC);
		end
		wait_halted();
		check_port_log();
		finish_test("reset_state");
	endtask

	task automatic test_alu_ops();
		logic [31:0] r;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] k;
		logic [15:0] v1;
		logic [15:0] v2;
		start_test();
		r = lcg_next();
		a = r[23:16];
		b = r[31:24];
		k = r[15:8];
		v1 = {8'h00, a} + sext8(k);
		v2 = {8'h00, b};
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd1, a));
		prog.push_back(enc_imm(cpu_pkg::OP_ADDI, 4'd1, k));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd2, b));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd15, 8'h40));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd1, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd3, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_SUB, 4'd4, 4'd1, 4'd2));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd4, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_AND, 4'd5, 4'd1, 4'd2));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd5, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_OR, 4'd6, 4'd1, 4'd2));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd6, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_XOR, 4'd7, 4'd1, 4'd2));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd7, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0));
		expect_out(16'h0040, v1);
		expect_out(16'h0040, v1 + v2);
		expect_out(16'h0040, v1 - v2);
		expect_out(16'h0040, v1 & v2);
		expect_out(16'h0040, v1 | v2);
		expect_out(16'h0040, v1 ^ v2);
		run_program();
		finish_test("alu_ops");
	endtask

	task automatic test_branch_zero();
		start_test();
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd1, 8'h05));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd2, 8'h05));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd15, 8'h41));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd10, 8'h01));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd11, 8'h02));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd12, 8'h03));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd13, 8'h04));
		// Zero result, so the branch skips one word.
		prog.push_back(enc_reg(cpu_pkg::OP_SUB, 4'd3, 4'd1, 4'd2));
		prog.push_back(enc_imm(cpu_pkg::OP_JZ, 4'd0, 8'h01));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd10, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd11, 4'd15, 4'd0));
		// Nonzero result, so execution falls through.
		prog.push_back(enc_reg(cpu_pkg::OP_XOR, 4'd4, 4'd1, 4'd12));
		prog.push_back(enc_imm(cpu_pkg::OP_JZ, 4'd0, 8'h01));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd12, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd13, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0));
		expect_out(16'h0041, 16'h0002);
		expect_out(16'h0041, 16'h0003);
		expect_out(16'h0041, 16'h0004);
		run_program();
		finish_test("branch_zero");
	endtask

	task automatic test_load_store();
		logic [31:0] r;
		logic [15:0] v;
		start_test();
		r = lcg_next();
		v = {8'h00, r[23:16]} + sext8(r[31:24]);
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd1, 8'h80));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd2, r[23:16]));
		prog.push_back(enc_imm(cpu_pkg::OP_ADDI, 4'd2, r[31:24]));
		prog.push_back(enc_reg(cpu_pkg::OP_ST, 4'd2, 4'd1, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_LD, 4'd3, 4'd1, 4'd0));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd15, 8'h42));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd3, 4'd15, 4'd0));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd4, 8'h90));
		prog.push_back(enc_reg(cpu_pkg::OP_LD, 4'd5, 4'd4, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd5, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0));
		expect_out(16'h0042, v);
		expect_out(16'h0042, fill_word(8'h90));
		run_program();
		compare_word("mem[80]", mem[8'h80], v);
		finish_test("load_store");
	endtask

	task automatic test_port_input();
		start_test();
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd1, 8'h12));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd2, 8'h34));
		prog.push_back(enc_reg(cpu_pkg::OP_IN, 4'd3, 4'd1, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_IN, 4'd4, 4'd2, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_ADD, 4'd5, 4'd3, 4'd4));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd15, 8'h43));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd5, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0));
		expect_out(16'h0043, port_value(16'h0012) + port_value(16'h0034));
		run_program();
		finish_test("port_input");
	endtask

	task automatic test_jump_halt();
		start_test();
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd1, 8'h07));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd15, 8'h44));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd10, 8'h11));
		prog.push_back(enc_imm(cpu_pkg::OP_LDI, 4'd11, 8'h22));
		prog.push_back(enc_reg(cpu_pkg::OP_JMP, 4'd0, 4'd1, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd10, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd10, 4'd15, 4'd0));
		// Jump target at word 7.
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd11, 4'd15, 4'd0));
		prog.push_back(enc_imm(cpu_pkg::OP_ADDI, 4'd11, 8'h01));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd11, 4'd15, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0));
		prog.push_back(enc_reg(cpu_pkg::OP_OUT, 4'd10, 4'd15, 4'd0));
		expect_out(16'h0044, 16'h0022);
		expect_out(16'h0044, 16'h0023);
		run_program();
		finish_test("jump_halt");
	endtask

	initial begin
		rst_n = 1'b0;
		memory_in = '0;
		memory_ready = 1'b0;
		port_in = '0;
		counting = 1'b0;
		waits = 2'd0;
		total_errors = 0;
		tests_run = 0;
		tests_failing = 0;
		test_reset_state();
		test_alu_ops();
		test_branch_zero();
		test_load_store();
		test_port_input();
		test_jump_halt();
		$display("tests run %0d, tests failing %0d, errors %0d",
			tests_run, tests_failing, total_errors);
		if (total_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_ifs.sv
verilog/cpu_decode.sv
verilog/cpu_register_file.sv
verilog/alu.sv
verilog/cpu_execute.sv
verilog/cpu_fetch.sv
verilog/cpu_memory_interface.sv
verilog/cpu_top.sv
sim/tb_clock.sv
sim/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vcpu_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
else
	echo "pass message not found in sim.log"
	exit 1
fi
